// ==== list.f ====
+incdir+include
src/cpu_bus_pkg.sv
src/mem_req_if.sv
src/bus_arbiter.sv
src/bus_xbar.sv
src/axi_master_port.sv
src/clint_timer.sv
src/mem_subsys_top.sv
bench/tb_mem_subsys.sv

// ==== Bender.yml ====
package:
  name: mem_subsys

export_include_dirs:
  - include

sources:
  - files:
      - src/cpu_bus_pkg.sv
      - src/mem_req_if.sv
      - src/bus_arbiter.sv
      - src/bus_xbar.sv
      - src/axi_master_port.sv
      - src/clint_timer.sv
      - src/mem_subsys_top.sv
  - target: test
    files:
      - bench/tb_mem_subsys.sv

// ==== bench/tb_mem_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_bus_defines.svh"

module tb_mem_subsys import cpu_bus_pkg::*; ();

	localparam int CYCLE_LIMIT = 4000;    // Several times the longest expected run
	localparam addr_t ERR_ADDR = 32'h8000_0F00;
	localparam addr_t MTIME_LO = `CLINT_BASE + `MTIME_OFS;
	localparam addr_t CMP_LO = `CLINT_BASE + `MTIMECMP_OFS;

	logic clock = 1'b0;
	logic rst_i;
	addr_t if_addr_i;
	logic if_valid_i, if_ready_o, if_rvalid_o, if_rready_i;
	data_t if_rdata_o;
	resp_t if_resp_o;
	addr_t d_addr_i;
	size_t d_size_i;
	logic d_write_i, d_valid_i, d_ready_o, d_rvalid_o, d_rready_i;
	data_t d_wdata_i, d_rdata_o;
	strb_t d_wstrb_i;
	resp_t d_resp_o;
	addr_t m_awaddr_o, m_araddr_o;
	axi_id_t m_awid_o, m_arid_o;
	logic [7:0] m_awlen_o, m_arlen_o;
	size_t m_awsize_o, m_arsize_o;
	logic [1:0] m_awburst_o, m_arburst_o;
	logic m_awvalid_o, m_wlast_o, m_wvalid_o, m_bready_o, m_arvalid_o, m_rready_o;
	data_t m_wdata_o;
	strb_t m_wstrb_o;
	logic timer_irq_o;

	// AXI slave model outputs
	logic m_awready_i = 1'b0;
	logic m_wready_i = 1'b0;
	logic m_arready_i = 1'b0;
	logic m_bvalid_i = 1'b0;
	logic m_rvalid_i = 1'b0;
	logic m_rlast_i = 1'b0;
	resp_t m_bresp_i = '0;
	resp_t m_rresp_i = '0;
	axi_id_t m_bid_i = '0;
	axi_id_t m_rid_i = '0;
	data_t m_rdata_i = '0;

	data_t slave_mem [addr_t];    // Model storage
	data_t ref_mem [addr_t];      // Expected contents
	addr_t aw_addr_seen, ar_addr_seen;
	axi_id_t aw_id_seen, ar_id_seen;
	logic [7:0] aw_len_seen, ar_len_seen;
	size_t aw_size_seen, ar_size_seen;
	logic [1:0] aw_burst_seen, ar_burst_seen;
	data_t w_data_seen;
	strb_t w_strb_seen;
	logic w_last_seen;
	logic watch_axi = 1'b0;
	logic axi_valid_seen = 1'b0;
	int cycle_count = 0;

	mem_subsys_top UUT (.*);

	always #20 clock = ~clock;

	function automatic data_t fill_word(addr_t a);
		return {a[15:0], a[31:16]} ^ 32'hC3A5_5A3C;
	endfunction

	function automatic data_t apply_strobes(data_t old_w, data_t new_w, strb_t be);
		data_t res;
		res = old_w;
		for (int i = 0; i < 4; i++)
			if (be[i])
				res[i*8 +: 8] = new_w[i*8 +: 8];
		return res;
	endfunction

	function automatic data_t model_word(addr_t a);
		return slave_mem.exists(a) ? slave_mem[a] : fill_word(a);
	endfunction

	function automatic data_t expected_word(addr_t a);
		return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
	endfunction

	function automatic logic [48:0] aw_fields();
		return {m_awaddr_o, m_awid_o, m_awlen_o, m_awsize_o, m_awburst_o};
	endfunction

	function automatic logic [48:0] ar_fields();
		return {m_araddr_o, m_arid_o, m_arlen_o, m_arsize_o, m_arburst_o};
	endfunction

	task automatic stop_run();
		$display("*** TEST FAILED ***");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic report_error(input string msg);
		$display("ERROR at %0t ns: %s", $time, msg);
		stop_run();
	endtask

	task automatic check_data(input string what, input data_t got, input data_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_resp(input string what, input resp_t got, input resp_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_id(input string what, input axi_id_t got, input axi_id_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_size(input string what, input size_t got, input size_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_field(input string what, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
			stop_run();
		end
	endtask

	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			stop_run();
		end
	end

	always @(negedge clock)
		if (watch_axi && (m_arvalid_o || m_awvalid_o || m_wvalid_o))
			axi_valid_seen = 1'b1;

	// AW and W accept tasks start on the negedge where valid is first seen
	task automatic accept_aw();
		logic [48:0] snap;
		int d;
		snap = aw_fields();
		d = $urandom % 4;
		repeat (d) begin
			@(negedge clock);
			if (!m_awvalid_o || aw_fields() !== snap)
				report_error("AW channel changed while awvalid waited");
		end
		@(posedge clock);
		m_awready_i <= 1'b1;
		@(negedge clock);
		if (!m_awvalid_o || aw_fields() !== snap)
			report_error("AW channel changed while awvalid waited");
		{aw_addr_seen, aw_id_seen, aw_len_seen, aw_size_seen, aw_burst_seen} = snap;
		@(posedge clock);
		m_awready_i <= 1'b0;
	endtask

	task automatic accept_w();
		logic [36:0] snap;
		int d;
		snap = {m_wdata_o, m_wstrb_o, m_wlast_o};
		d = $urandom % 4;
		repeat (d) begin
			@(negedge clock);
			if (!m_wvalid_o || {m_wdata_o, m_wstrb_o, m_wlast_o} !== snap)
				report_error("W channel changed while wvalid waited");
		end
		@(posedge clock);
		m_wready_i <= 1'b1;
		@(negedge clock);
		if (!m_wvalid_o || {m_wdata_o, m_wstrb_o, m_wlast_o} !== snap)
			report_error("W channel changed while wvalid waited");
		w_data_seen = m_wdata_o;
		w_strb_seen = m_wstrb_o;
		w_last_seen = m_wlast_o;
		@(posedge clock);
		m_wready_i <= 1'b0;
	endtask

	always begin : write_slave
		int d;
		addr_t wa;
		@(negedge clock);
		if (m_awvalid_o && m_wvalid_o) begin
			fork
				accept_aw();
				accept_w();
			join
			wa = aw_addr_seen & ~32'h3;
			if (aw_addr_seen == ERR_ADDR) begin
				m_bresp_i <= RESP_SLVERR;
			end else begin
				slave_mem[wa] = apply_strobes(model_word(wa), w_data_seen, w_strb_seen);
				m_bresp_i <= RESP_OKAY;
			end
			d = $urandom % 4;
			repeat (d) @(posedge clock);
			m_bvalid_i <= 1'b1;
			m_bid_i <= aw_id_seen;
			@(negedge clock);
			while (!m_bready_o) @(negedge clock);
			@(posedge clock);
			m_bvalid_i <= 1'b0;
		end
	end

	always begin : read_slave
		logic [48:0] snap;
		int d;
		@(negedge clock);
		if (m_arvalid_o) begin
			snap = ar_fields();
			d = $urandom % 4;
			repeat (d) begin
				@(negedge clock);
				if (!m_arvalid_o || ar_fields() !== snap)
					report_error("AR channel changed while arvalid waited");
			end
			@(posedge clock);
			m_arready_i <= 1'b1;
			@(negedge clock);
			if (!m_arvalid_o || ar_fields() !== snap)
				report_error("AR channel changed while arvalid waited");
			{ar_addr_seen, ar_id_seen, ar_len_seen, ar_size_seen, ar_burst_seen} = snap;
			@(posedge clock);
			m_arready_i <= 1'b0;
			d = $urandom % 4;
			repeat (d) @(posedge clock);
			m_rvalid_i <= 1'b1;
			m_rlast_i <= 1'b1;
			m_rid_i <= ar_id_seen;
			if (ar_addr_seen == ERR_ADDR) begin
				m_rdata_i <= '0;
				m_rresp_i <= RESP_SLVERR;
			end else begin
				m_rdata_i <= model_word(ar_addr_seen & ~32'h3);
				m_rresp_i <= RESP_OKAY;
			end
			@(negedge clock);
			while (!m_rready_o) @(negedge clock);
			@(posedge clock);
			m_rvalid_i <= 1'b0;
		end
	end

	task automatic fetch_word(input addr_t addr, output data_t rdata, output resp_t resp);
		@(posedge clock);
		if_addr_i <= addr;
		if_valid_i <= 1'b1;
		@(negedge clock);
		while (!if_ready_o) @(negedge clock);
		@(posedge clock);
		if_valid_i <= 1'b0;
		@(negedge clock);
		while (!if_rvalid_o) @(negedge clock);
		rdata = if_rdata_o;
		resp = if_resp_o;
	endtask

	task automatic data_access(input addr_t addr, input logic wr, input data_t wdata,
		input strb_t strb, output data_t rdata, output resp_t resp);
		@(posedge clock);
		d_addr_i <= addr;
		d_write_i <= wr;
		d_wdata_i <= wdata;
		d_wstrb_i <= strb;
		d_size_i <= 3'd2;
		d_valid_i <= 1'b1;
		@(negedge clock);
		while (!d_ready_o) @(negedge clock);
		@(posedge clock);
		d_valid_i <= 1'b0;
		@(negedge clock);
		while (!d_rvalid_o) @(negedge clock);
		rdata = d_rdata_o;
		resp = d_resp_o;
		if (wr && resp == RESP_OKAY)
			ref_mem[addr] = apply_strobes(expected_word(addr), wdata, strb);
	endtask

	task automatic test_fetch();
		data_t rd;
		resp_t rs;
		fetch_word(32'h8000_0000, rd, rs);
		check_data("fetch data", rd, expected_word(32'h8000_0000));
		check_resp("fetch resp", rs, RESP_OKAY);
		check_id("arid", ar_id_seen, ID_INST);
		check_field("arlen", ar_len_seen, 8'd0);
		check_size("arsize", ar_size_seen, 3'd2);
		check_field("arburst", {6'd0, ar_burst_seen}, 8'd1);
	endtask

	task automatic test_partial_write();
		data_t rd, old_w;
		resp_t rs;
		old_w = expected_word(32'h8000_0100);
		data_access(32'h8000_0100, 1'b1, 32'h1234_5678, 4'h3, rd, rs);
		check_resp("write resp", rs, RESP_OKAY);
		check_id("awid", aw_id_seen, ID_DATA);
		check_field("awlen", aw_len_seen, 8'd0);
		check_size("awsize", aw_size_seen, 3'd2);
		check_field("awburst", {6'd0, aw_burst_seen}, 8'd1);
		check_field("wlast", {7'd0, w_last_seen}, 8'd1);
		data_access(32'h8000_0100, 1'b0, '0, '0, rd, rs);
		check_data("merged word", rd, {old_w[31:16], 16'h5678});
	endtask

	task automatic test_priority();
		data_t rd_if, rd_d;
		resp_t rs_if, rs_d;
		time t_if, t_d;
		fork
			begin
				fetch_word(32'h8000_0200, rd_if, rs_if);
				t_if = $time;
			end
			begin
				data_access(32'h8000_0300, 1'b0, '0, '0, rd_d, rs_d);
				t_d = $time;
			end
		join
		if (t_d >= t_if)
			report_error("fetch response came back before the data response");
		check_data("priority fetch", rd_if, expected_word(32'h8000_0200));
		check_data("priority data", rd_d, expected_word(32'h8000_0300));
	endtask

	task automatic test_random_mix();
		data_t rd;
		resp_t rs;
		addr_t a;
		int kind;
		for (int n = 0; n < 20; n++) begin
			kind = $urandom % 3;
			a = 32'h8000_1000 + (($urandom % 64) << 2);
			if (kind == 0) begin
				fetch_word(a, rd, rs);
				check_data("random fetch", rd, expected_word(a));
			end else if (kind == 1) begin
				data_access(a, 1'b0, '0, '0, rd, rs);
				check_data("random read", rd, expected_word(a));
			end else begin
				data_access(a, 1'b1, $urandom, strb_t'(($urandom % 15) + 1), rd, rs);
			end
			check_resp("random resp", rs, RESP_OKAY);
		end
		// Every written word read back once
		foreach (ref_mem[k]) begin
			data_access(k, 1'b0, '0, '0, rd, rs);
			check_data("readback", rd, ref_mem[k]);
			check_resp("readback resp", rs, RESP_OKAY);
		end
	endtask

	task automatic test_timer();
		data_t t1, t2, rd;
		resp_t rs;
		int waited;
		axi_valid_seen = 1'b0;
		watch_axi = 1'b1;
		data_access(MTIME_LO, 1'b0, '0, '0, t1, rs);
		data_access(MTIME_LO, 1'b0, '0, '0, t2, rs);
		watch_axi = 1'b0;
		if (!(t2 > t1))
			report_error("mtime did not increase between two reads");
		if (axi_valid_seen)
			report_error("an AXI valid rose during a timer access");
		data_access(CMP_LO + 32'd4, 1'b1, '0, 4'hF, rd, rs);
		check_resp("mtimecmp high write", rs, RESP_OKAY);
		data_access(CMP_LO, 1'b1, t2 + 32'd50, 4'hF, rd, rs);
		check_resp("mtimecmp low write", rs, RESP_OKAY);
		if (timer_irq_o !== 1'b0)
			report_error("timer interrupt was high before mtimecmp was reached");
		waited = 0;
		while (!timer_irq_o && waited < 60) begin
			@(negedge clock);
			waited++;
		end
		if (timer_irq_o !== 1'b1)
			report_error("timer interrupt did not rise within 60 cycles");
		data_access(`CLINT_BASE + 32'h10, 1'b0, '0, '0, rd, rs);
		check_resp("timer bad offset", rs, RESP_SLVERR);
	endtask

	task automatic test_slave_error();
		data_t rd;
		resp_t rs;
		data_access(ERR_ADDR, 1'b0, '0, '0, rd, rs);
		check_resp("error read", rs, RESP_SLVERR);
		data_access(ERR_ADDR, 1'b1, 32'hDEAD_BEEF, 4'hF, rd, rs);
		check_resp("error write", rs, RESP_SLVERR);
	endtask

	initial begin
		rst_i = 1'b1;
		if_addr_i = '0;
		if_valid_i = 1'b0;
		if_rready_i = 1'b0;
		d_addr_i = '0;
		d_size_i = '0;
		d_write_i = 1'b0;
		d_wdata_i = '0;
		d_wstrb_i = '0;
		d_valid_i = 1'b0;
		d_rready_i = 1'b0;
		void'($urandom(7));
		repeat (4) @(posedge clock);
		rst_i <= 1'b0;
		if_rready_i <= 1'b1;    // CPU always takes responses
		d_rready_i <= 1'b1;
		test_fetch();
		test_partial_write();
		test_priority();
		test_random_mix();
		test_timer();
		test_slave_error();
		repeat (2) @(posedge clock);
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src/mem_subsys_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top import cpu_bus_pkg::*; (
	input  logic       clock,
	input  logic       rst_i,

	// Fetch port
	input  addr_t      if_addr_i,
	input  logic       if_valid_i,
	output logic       if_ready_o,
	output data_t      if_rdata_o,
	output resp_t      if_resp_o,
	output logic       if_rvalid_o,
	input  logic       if_rready_i,

	// Data port
	input  addr_t      d_addr_i,
	input  size_t      d_size_i,
	input  logic       d_write_i,
	input  data_t      d_wdata_i,
	input  strb_t      d_wstrb_i,
	input  logic       d_valid_i,
	output logic       d_ready_o,
	output data_t      d_rdata_o,
	output resp_t      d_resp_o,
	output logic       d_rvalid_o,
	input  logic       d_rready_i,

	// AXI4 master
	output addr_t      m_awaddr_o,
	output axi_id_t    m_awid_o,
	output logic [7:0] m_awlen_o,
	output size_t      m_awsize_o,
	output logic [1:0] m_awburst_o,
	output logic       m_awvalid_o,
	input  logic       m_awready_i,
	output data_t      m_wdata_o,
	output strb_t      m_wstrb_o,
	output logic       m_wlast_o,
	output logic       m_wvalid_o,
	input  logic       m_wready_i,
	input  resp_t      m_bresp_i,
	input  axi_id_t    m_bid_i,
	input  logic       m_bvalid_i,
	output logic       m_bready_o,
	output addr_t      m_araddr_o,
	output axi_id_t    m_arid_o,
	output logic [7:0] m_arlen_o,
	output size_t      m_arsize_o,
	output logic [1:0] m_arburst_o,
	output logic       m_arvalid_o,
	input  logic       m_arready_i,
	input  data_t      m_rdata_i,
	input  resp_t      m_rresp_i,
	input  logic       m_rlast_i,
	input  axi_id_t    m_rid_i,
	input  logic       m_rvalid_i,
	output logic       m_rready_o,

	output logic       timer_irq_o
);

	mem_req_if arb_bus ();
	mem_req_if axi_bus ();

	logic  clint_req;
	logic  clint_ready;
	addr_t clint_addr;
	logic  clint_write;
	data_t clint_wdata;
	strb_t clint_wstrb;
	logic  clint_rsp_valid;
	data_t clint_rdata;
	resp_t clint_resp;
	logic  clint_rsp_ready;

	bus_arbiter u_arbiter (
		.clock       (clock),
		.rst_i       (rst_i),
		.if_addr_i   (if_addr_i),
		.if_valid_i  (if_valid_i),
		.if_ready_o  (if_ready_o),
		.if_rdata_o  (if_rdata_o),
		.if_resp_o   (if_resp_o),
		.if_rvalid_o (if_rvalid_o),
		.if_rready_i (if_rready_i),
		.d_addr_i    (d_addr_i),
		.d_size_i    (d_size_i),
		.d_write_i   (d_write_i),
		.d_wdata_i   (d_wdata_i),
		.d_wstrb_i   (d_wstrb_i),
		.d_valid_i   (d_valid_i),
		.d_ready_o   (d_ready_o),
		.d_rdata_o   (d_rdata_o),
		.d_resp_o    (d_resp_o),
		.d_rvalid_o  (d_rvalid_o),
		.d_rready_i  (d_rready_i),
		.bus         (arb_bus.master)
	);

	bus_xbar u_xbar (
		.clock             (clock),
		.rst_i             (rst_i),
		.up                (arb_bus.slave),
		.axi               (axi_bus.master),
		.clint_req_o       (clint_req),
		.clint_ready_i     (clint_ready),
		.clint_addr_o      (clint_addr),
		.clint_write_o     (clint_write),
		.clint_wdata_o     (clint_wdata),
		.clint_wstrb_o     (clint_wstrb),
		.clint_rsp_valid_i (clint_rsp_valid),
		.clint_rdata_i     (clint_rdata),
		.clint_resp_i      (clint_resp),
		.clint_rsp_ready_o (clint_rsp_ready)
	);

	axi_master_port u_axi (
		.clock       (clock),
		.rst_i       (rst_i),
		.req         (axi_bus.slave),
		.m_awaddr_o  (m_awaddr_o),
		.m_awid_o    (m_awid_o),
		.m_awlen_o   (m_awlen_o),
		.m_awsize_o  (m_awsize_o),
		.m_awburst_o (m_awburst_o),
		.m_awvalid_o (m_awvalid_o),
		.m_awready_i (m_awready_i),
		.m_wdata_o   (m_wdata_o),
		.m_wstrb_o   (m_wstrb_o),
		.m_wlast_o   (m_wlast_o),
		.m_wvalid_o  (m_wvalid_o),
		.m_wready_i  (m_wready_i),
		.m_bresp_i   (m_bresp_i),
		.m_bid_i     (m_bid_i),
		.m_bvalid_i  (m_bvalid_i),
		.m_bready_o  (m_bready_o),
		.m_araddr_o  (m_araddr_o),
		.m_arid_o    (m_arid_o),
		.m_arlen_o   (m_arlen_o),
		.m_arsize_o  (m_arsize_o),
		.m_arburst_o (m_arburst_o),
		.m_arvalid_o (m_arvalid_o),
		.m_arready_i (m_arready_i),
		.m_rdata_i   (m_rdata_i),
		.m_rresp_i   (m_rresp_i),
		.m_rlast_i   (m_rlast_i),
		.m_rid_i     (m_rid_i),
		.m_rvalid_i  (m_rvalid_i),
		.m_rready_o  (m_rready_o)
	);

	clint_timer u_clint (
		.clock       (clock),
		.rst_i       (rst_i),
		.addr_i      (clint_addr),
		.write_i     (clint_write),
		.wdata_i     (clint_wdata),
		.wstrb_i     (clint_wstrb),
		.req_i       (clint_req),
		.ready_o     (clint_ready),
		.rsp_valid_o (clint_rsp_valid),
		.rdata_o     (clint_rdata),
		.resp_o      (clint_resp),
		.rsp_ready_i (clint_rsp_ready),
		.timer_irq_o (timer_irq_o)
	);

endmodule

`default_nettype wire

// ==== src/clint_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_bus_defines.svh"

module clint_timer import cpu_bus_pkg::*; (
	input  logic  clock,
	input  logic  rst_i,
	input  addr_t addr_i,
	input  logic  write_i,
	input  data_t wdata_i,
	input  strb_t wstrb_i,
	input  logic  req_i,
	output logic  ready_o,
	output logic  rsp_valid_o,
	output data_t rdata_o,
	output resp_t resp_o,
	input  logic  rsp_ready_i,
	output logic  timer_irq_o
);

	logic [63:0] mtime_q;
	logic [63:0] mtimecmp_q;
	logic [63:0] mtime_inc;
	logic [15:0] ofs;
	logic take;
	logic hit;
	data_t rd_word;

	function automatic data_t lane_merge(data_t old_w, data_t new_w, strb_t be);
		data_t res;
		res = old_w;
		for (int i = 0; i < $bits(strb_t); i++)
			if (be[i])
				res[i*8 +: 8] = new_w[i*8 +: 8];
		return res;
	endfunction

	assign ofs = addr_i[15:0];
	assign ready_o = !rsp_valid_o;    // One access at a time
	assign take = req_i && ready_o;
	assign mtime_inc = mtime_q + 64'd1;

	always_comb begin
		hit = 1'b1;
		rd_word = '0;
		case (ofs)
			`MTIMECMP_OFS: rd_word = mtimecmp_q[31:0];
			`MTIMECMP_OFS + 16'd4: rd_word = mtimecmp_q[63:32];
			`MTIME_OFS: rd_word = mtime_q[31:0];
			`MTIME_OFS + 16'd4: rd_word = mtime_q[63:32];
			default: hit = 1'b0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst_i) begin
			mtime_q <= '0;
			mtimecmp_q <= '1;
			rsp_valid_o <= 1'b0;
			timer_irq_o <= 1'b0;
		end else begin
			mtime_q <= mtime_inc;
			timer_irq_o <= (mtime_q >= mtimecmp_q);
			if (take && write_i) begin
				case (ofs)
					`MTIMECMP_OFS:
						mtimecmp_q[31:0] <= lane_merge(mtimecmp_q[31:0], wdata_i, wstrb_i);
					`MTIMECMP_OFS + 16'd4:
						mtimecmp_q[63:32] <= lane_merge(mtimecmp_q[63:32], wdata_i, wstrb_i);
					`MTIME_OFS:
						mtime_q <= {mtime_inc[63:32], lane_merge(mtime_q[31:0], wdata_i, wstrb_i)};
					`MTIME_OFS + 16'd4:
						mtime_q <= {lane_merge(mtime_q[63:32], wdata_i, wstrb_i), mtime_inc[31:0]};
					default: ;
				endcase
			end
			if (take)
				rsp_valid_o <= 1'b1;
			else if (rsp_ready_i)
				rsp_valid_o <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (take) begin
			rdata_o <= rd_word;
			resp_o <= hit ? RESP_OKAY : RESP_SLVERR;
		end
	end

endmodule

`default_nettype wire

// ==== src/axi_master_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_master_port import cpu_bus_pkg::*; (
	input  logic       clock,
	input  logic       rst_i,

	mem_req_if.slave   req,

	// Write address
	output addr_t      m_awaddr_o,
	output axi_id_t    m_awid_o,
	output logic [7:0] m_awlen_o,
	output size_t      m_awsize_o,
	output logic [1:0] m_awburst_o,
	output logic       m_awvalid_o,
	input  logic       m_awready_i,

	// Write data
	output data_t      m_wdata_o,
	output strb_t      m_wstrb_o,
	output logic       m_wlast_o,
	output logic       m_wvalid_o,
	input  logic       m_wready_i,

	// Write response
	input  resp_t      m_bresp_i,
	input  axi_id_t    m_bid_i,
	input  logic       m_bvalid_i,
	output logic       m_bready_o,

	// Read address
	output addr_t      m_araddr_o,
	output axi_id_t    m_arid_o,
	output logic [7:0] m_arlen_o,
	output size_t      m_arsize_o,
	output logic [1:0] m_arburst_o,
	output logic       m_arvalid_o,
	input  logic       m_arready_i,

	// Read data
	input  data_t      m_rdata_i,
	input  resp_t      m_rresp_i,
	input  logic       m_rlast_i,
	input  axi_id_t    m_rid_i,
	input  logic       m_rvalid_i,
	output logic       m_rready_o
);

	axi_state_e state_q;
	logic aw_done_q;
	logic w_done_q;
	logic aw_ok;
	logic w_ok;

	addr_t addr_q;
	logic write_q;
	size_t size_q;
	data_t wdata_q;
	strb_t wstrb_q;
	axi_id_t id_q;
	data_t rdata_q;
	resp_t resp_q;

	assign req.req_ready = (state_q == AXI_IDLE);
	assign req.rsp_valid = (state_q == DONE);
	assign req.rdata = rdata_q;
	assign req.resp = resp_q;

	// AW and W may complete in either order
	assign m_awvalid_o = (state_q == ADDR) && write_q && !aw_done_q;
	assign m_wvalid_o = (state_q == ADDR) && write_q && !w_done_q;
	assign m_arvalid_o = (state_q == ADDR) && !write_q;
	assign m_bready_o = (state_q == WAIT_B);
	assign m_rready_o = (state_q == WAIT_R);

	assign aw_ok = aw_done_q || m_awready_i;
	assign w_ok = w_done_q || m_wready_i;

	assign m_awaddr_o = addr_q;
	assign m_awid_o = id_q;
	assign m_awlen_o = 8'd0;    // Single beat
	assign m_awsize_o = size_q;
	assign m_awburst_o = 2'b01;    // INCR
	assign m_wdata_o = wdata_q;
	assign m_wstrb_o = wstrb_q;
	assign m_wlast_o = 1'b1;
	assign m_araddr_o = addr_q;
	assign m_arid_o = id_q;
	assign m_arlen_o = 8'd0;
	assign m_arsize_o = size_q;
	assign m_arburst_o = 2'b01;

	always_ff @(posedge clock) begin
		if (rst_i) begin
			state_q <= AXI_IDLE;
			aw_done_q <= 1'b0;
			w_done_q <= 1'b0;
		end else begin
			case (state_q)
				AXI_IDLE: begin
					aw_done_q <= 1'b0;
					w_done_q <= 1'b0;
					if (req.req_valid)
						state_q <= ADDR;
				end
				ADDR: begin
					if (write_q) begin
						if (m_awvalid_o && m_awready_i)
							aw_done_q <= 1'b1;
						if (m_wvalid_o && m_wready_i)
							w_done_q <= 1'b1;
						if (aw_ok && w_ok)
							state_q <= WAIT_B;
					end else if (m_arready_i) begin
						state_q <= WAIT_R;
					end
				end
				WAIT_B: if (m_bvalid_i) state_q <= DONE;
				WAIT_R: if (m_rvalid_i) state_q <= DONE;
				DONE: if (req.rsp_ready) state_q <= AXI_IDLE;
				default: state_q <= AXI_IDLE;
			endcase
		end
	end

	// Request fields and the returned beat
	always_ff @(posedge clock) begin
		if (req.req_valid && req.req_ready) begin
			addr_q <= req.addr;
			write_q <= req.write;
			size_q <= req.size;
			wdata_q <= req.wdata;
			wstrb_q <= req.wstrb;
			id_q <= req.id;
		end
		if (m_bvalid_i && m_bready_o)
			resp_q <= m_bresp_i;
		if (m_rvalid_i && m_rready_o) begin
			rdata_q <= m_rdata_i;
			resp_q <= m_rresp_i;
		end
	end

	a_aw_hold: assert property (@(posedge clock) disable iff (rst_i)
		(m_awvalid_o && !m_awready_i) |=> (m_awvalid_o && $stable(m_awaddr_o)));

	a_rid: assert property (@(posedge clock) disable iff (rst_i)
		(m_rvalid_i && m_rready_o) |-> (m_rid_i == id_q && m_rlast_i));

	a_bid: assert property (@(posedge clock) disable iff (rst_i)
		(m_bvalid_i && m_bready_o) |-> (m_bid_i == id_q));

endmodule

`default_nettype wire

// ==== src/bus_xbar.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_bus_defines.svh"

module bus_xbar import cpu_bus_pkg::*; (
	input  logic  clock,
	input  logic  rst_i,

	mem_req_if.slave  up,
	mem_req_if.master axi,

	// Timer target
	output logic  clint_req_o,
	input  logic  clint_ready_i,
	output addr_t clint_addr_o,
	output logic  clint_write_o,
	output data_t clint_wdata_o,
	output strb_t clint_wstrb_o,
	input  logic  clint_rsp_valid_i,
	input  data_t clint_rdata_i,
	input  resp_t clint_resp_i,
	output logic  clint_rsp_ready_o
);

	logic hit;
	logic sel_clint_q;    // Target of the open transaction

	assign hit = (up.addr & `CLINT_MASK) == `CLINT_BASE;

	assign clint_req_o = up.req_valid && hit;
	assign axi.req_valid = up.req_valid && !hit;
	assign up.req_ready = hit ? clint_ready_i : axi.req_ready;

	assign clint_addr_o = up.addr;
	assign clint_write_o = up.write;
	assign clint_wdata_o = up.wdata;
	assign clint_wstrb_o = up.wstrb;

	assign axi.addr = up.addr;
	assign axi.write = up.write;
	assign axi.size = up.size;
	assign axi.wdata = up.wdata;
	assign axi.wstrb = up.wstrb;
	assign axi.id = up.id;

	// Responses follow the registered target
	assign up.rsp_valid = sel_clint_q ? clint_rsp_valid_i : axi.rsp_valid;
	assign up.rdata = sel_clint_q ? clint_rdata_i : axi.rdata;
	assign up.resp = sel_clint_q ? clint_resp_i : axi.resp;
	assign clint_rsp_ready_o = sel_clint_q && up.rsp_ready;
	assign axi.rsp_ready = !sel_clint_q && up.rsp_ready;

	always_ff @(posedge clock) begin
		if (rst_i)
			sel_clint_q <= 1'b0;
		else if (up.req_valid && up.req_ready)
			sel_clint_q <= hit;
	end

	// Only the selected target may hold a response
	a_one_target: assert property (@(posedge clock) disable iff (rst_i)
		sel_clint_q ? !axi.rsp_valid : !clint_rsp_valid_i);

endmodule

`default_nettype wire

// ==== src/bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter import cpu_bus_pkg::*; (
	input  logic  clock,
	input  logic  rst_i,

	// Instruction fetch
	input  addr_t if_addr_i,
	input  logic  if_valid_i,
	output logic  if_ready_o,
	output data_t if_rdata_o,
	output resp_t if_resp_o,
	output logic  if_rvalid_o,
	input  logic  if_rready_i,

	// Data access
	input  addr_t d_addr_i,
	input  size_t d_size_i,
	input  logic  d_write_i,
	input  data_t d_wdata_i,
	input  strb_t d_wstrb_i,
	input  logic  d_valid_i,
	output logic  d_ready_o,
	output data_t d_rdata_o,
	output resp_t d_resp_o,
	output logic  d_rvalid_o,
	input  logic  d_rready_i,

	mem_req_if.master bus
);

	arb_state_e state_q;
	axi_id_t owner_q;
	logic open_q;
	logic own_data;
	logic req_hs;
	logic rsp_hs;

	// Data port has priority
	assign bus.req_valid = (state_q == IDLE) && (if_valid_i || d_valid_i);
	assign bus.addr = d_valid_i ? d_addr_i : if_addr_i;
	assign bus.write = d_valid_i && d_write_i;
	assign bus.size = d_valid_i ? d_size_i : 3'd2;
	assign bus.wdata = d_valid_i ? d_wdata_i : '0;
	assign bus.wstrb = d_valid_i ? d_wstrb_i : '0;
	assign bus.id = d_valid_i ? ID_DATA : ID_INST;

	assign d_ready_o = (state_q == IDLE) && bus.req_ready;
	assign if_ready_o = (state_q == IDLE) && bus.req_ready && !d_valid_i;

	assign req_hs = bus.req_valid && bus.req_ready;
	assign rsp_hs = bus.rsp_valid && bus.rsp_ready;

	// Response goes back to whoever owns the open transaction
	assign open_q = (state_q != IDLE);
	assign own_data = (owner_q == ID_DATA);
	assign bus.rsp_ready = open_q && (own_data ? d_rready_i : if_rready_i);

	assign d_rvalid_o = open_q && own_data && bus.rsp_valid;
	assign if_rvalid_o = open_q && !own_data && bus.rsp_valid;
	assign d_rdata_o = bus.rdata;
	assign d_resp_o = bus.resp;
	assign if_rdata_o = bus.rdata;
	assign if_resp_o = bus.resp;

	always_ff @(posedge clock) begin
		if (rst_i) begin
			state_q <= IDLE;
			owner_q <= ID_INST;
		end else begin
			case (state_q)
				IDLE: if (req_hs) begin
					state_q <= BUSY;
					owner_q <= bus.id;
				end
				BUSY: begin
					if (rsp_hs)
						state_q <= IDLE;
					else if (bus.rsp_valid)
						state_q <= RESP;    // Owner stalls the response
				end
				RESP: if (rsp_hs) state_q <= IDLE;
				default: state_q <= IDLE;
			endcase
		end
	end

	// No response may arrive without an open transaction
	a_idle_no_rsp: assert property (@(posedge clock) disable iff (rst_i)
		(state_q == IDLE) |-> !bus.rsp_valid);

	// A stalled response must be held by the target below
	a_resp_held: assert property (@(posedge clock) disable iff (rst_i)
		(state_q == RESP) |-> bus.rsp_valid);

endmodule

`default_nettype wire

// ==== src/mem_req_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface mem_req_if import cpu_bus_pkg::*; ();

	// Request side
	logic    req_valid;
	logic    req_ready;
	addr_t   addr;
	logic    write;
	size_t   size;
	data_t   wdata;
	strb_t   wstrb;
	axi_id_t id;

	// Response side
	logic    rsp_valid;
	logic    rsp_ready;
	data_t   rdata;
	resp_t   resp;

	modport master (
		output req_valid, addr, write, size, wdata, wstrb, id, rsp_ready,
		input  req_ready, rsp_valid, rdata, resp
	);

	modport slave (
		input  req_valid, addr, write, size, wdata, wstrb, id, rsp_ready,
		output req_ready, rsp_valid, rdata, resp
	);

endinterface

`default_nettype wire

// ==== src/cpu_bus_pkg.sv ====
`default_nettype none

`include "cpu_bus_defines.svh"

package cpu_bus_pkg;

	typedef logic [`ADDR_LEN-1:0] addr_t;
	typedef logic [`DATA_LEN-1:0] data_t;
	typedef logic [3:0] strb_t;
	typedef logic [2:0] size_t;    // log2 of bytes
	typedef logic [1:0] resp_t;
	typedef logic [3:0] axi_id_t;

	localparam resp_t RESP_OKAY = 2'd0;
	localparam resp_t RESP_SLVERR = 2'd2;

	localparam axi_id_t ID_INST = 4'd0;
	localparam axi_id_t ID_DATA = 4'd1;

	typedef enum logic [1:0] {
		IDLE,
		BUSY,
		RESP
	} arb_state_e;

	typedef enum logic [2:0] {
		AXI_IDLE,
		ADDR,
		WAIT_B,
		WAIT_R,
		DONE
	} axi_state_e;

endpackage

`default_nettype wire

// ==== include/cpu_bus_defines.svh ====
`ifndef CPU_BUS_DEFINES_SVH
`define CPU_BUS_DEFINES_SVH

// Bus widths
`define ADDR_LEN 32
`define DATA_LEN 32

// Core-local timer region
`define CLINT_BASE 32'h0200_0000
`define CLINT_MASK 32'hFFFF_0000

// Word offsets inside the timer region, high words sit 4 above
`define MTIMECMP_OFS 16'h4000
`define MTIME_OFS 16'hBFF8

`endif
